//--- hw/loader_pkg.sv
package loader_pkg;

    localparam int DMEM_A_LEN = 14;  // data memory address width
    localparam int WORD_W     = 16;  // host word
    localparam int BYTE_W     = 8;   // data memory byte
    localparam int LEN_W      = 15;  // word count, up to 16384
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;

    // host register map
    typedef enum logic [1:0] {
        REG_START  = 2'd0,
        REG_LENGTH = 2'd1,  // write kicks off a job
        REG_DATA   = 2'd2,
        REG_STATUS = 2'd3   // read only
    } host_reg_e;

    typedef enum logic [1:0] {
        L_IDLE,
        L_POP,
        L_WRITE,
        L_DONE
    } loader_state_e;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [1:0]        adr;
        logic [WORD_W-1:0] dat;
    } host_wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [WORD_W-1:0] dat;
    } host_wb_rsp_t;

    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [DMEM_A_LEN-1:0] adr;
        logic [BYTE_W-1:0]     dat;
    } dmem_wb_req_t;

    typedef struct packed {
        logic ack;
    } dmem_wb_rsp_t;

    typedef struct packed {
        logic [DMEM_A_LEN-1:0] start;
        logic [LEN_W-1:0]      length;
    } load_job_t;

endpackage

//--- hw/host_write_port.sv
`timescale 1ns/10ps

module host_write_port
    import loader_pkg::*;
(
    input  logic                dmem_ref_clk,
    input  logic                rst_n,
    input  host_wb_req_t        host_req,
    output host_wb_rsp_t        host_rsp,
    output logic                push,
    output logic [WORD_W-1:0]   push_data,
    input  logic                full,
    output logic                job_start,
    output load_job_t           job,
    input  logic                job_done
);

    host_reg_e             reg_sel;
    logic                  access;
    logic                  is_data_wr;
    logic                  fire;
    logic                  take_word;
    logic                  ack_q;
    logic [WORD_W-1:0]     rdat_q;
    logic                  busy_q;
    logic                  job_start_q;
    logic [DMEM_A_LEN-1:0] start_q;
    logic [LEN_W-1:0]      length_q;
    logic [LEN_W-1:0]      accepted_q;

    assign reg_sel    = host_reg_e'(host_req.adr);
    assign access     = host_req.cyc && host_req.stb && !ack_q; // new access, not yet acked
    assign is_data_wr = host_req.we && (reg_sel == REG_DATA);

    // data write against a full buffer waits, ack stretches
    assign fire      = access && !(is_data_wr && full);
    assign take_word = busy_q && (accepted_q != length_q);

    assign push      = fire && is_data_wr && take_word;
    assign push_data = host_req.dat;

    always_ff @(posedge dmem_ref_clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q       <= 1'b0;
            busy_q      <= 1'b0;
            job_start_q <= 1'b0;
            start_q     <= '0;
            length_q    <= '0;
            accepted_q  <= '0;
        end else begin
            ack_q       <= fire;
            job_start_q <= 1'b0;
            if (job_done)
                busy_q <= 1'b0;  // falls the cycle after done
            if (push)
                accepted_q <= accepted_q + 1'b1;
            // setup registers are frozen while a job runs
            if (fire && host_req.we && !busy_q) begin
                case (reg_sel)
                    REG_START: begin
                        start_q <= host_req.dat[DMEM_A_LEN-1:0];
                    end
                    REG_LENGTH: begin
                        length_q   <= host_req.dat[LEN_W-1:0];
                        accepted_q <= '0;
                        if (host_req.dat[LEN_W-1:0] != '0) begin
                            busy_q      <= 1'b1;
                            job_start_q <= 1'b1;  // same edge as the ack
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // read data, only meaningful while ack is high
    always_ff @(posedge dmem_ref_clk) begin
        if (fire && !host_req.we) begin
            case (reg_sel)
                REG_START:  rdat_q <= {{(WORD_W-DMEM_A_LEN){1'b0}}, start_q};
                REG_LENGTH: rdat_q <= {{(WORD_W-LEN_W){1'b0}}, length_q};
                REG_STATUS: rdat_q <= {busy_q, accepted_q};
                default:    rdat_q <= '0;
            endcase
        end
    end

    assign host_rsp.ack = ack_q;
    assign host_rsp.dat = rdat_q;

    assign job_start    = job_start_q;
    assign job.start    = start_q;
    assign job.length   = length_q;

endmodule

//--- hw/word_fifo.sv
`timescale 1ns/10ps

module word_fifo
    import loader_pkg::*;
(
    input  logic              dmem_ref_clk,
    input  logic              rst_n,
    input  logic              push,
    input  logic [WORD_W-1:0] push_data,
    output logic              full,
    input  logic              pop,
    output logic              empty,
    output logic [WORD_W-1:0] head
);

    logic [WORD_W-1:0]  mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count_q;
    logic               do_push;
    logic               do_pop;

    assign full  = (count_q == (FIFO_AW+1)'(FIFO_DEPTH));
    assign empty = (count_q == '0);

    // overflow and underflow requests are ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head = mem[rd_ptr];  // oldest word, no read latency

    always_ff @(posedge dmem_ref_clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge dmem_ref_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // both or neither
            endcase
        end
    end

endmodule

//--- hw/dmem_loader.sv
`timescale 1ns/10ps

module dmem_loader
    import loader_pkg::*;
(
    input  logic              dmem_ref_clk,
    input  logic              rst_n,
    input  logic              job_start,
    input  load_job_t         job,
    output logic              job_done,
    input  logic              empty,
    input  logic [WORD_W-1:0] head,
    output logic              pop,
    output dmem_wb_req_t      dmem_req,
    input  dmem_wb_rsp_t      dmem_rsp
);

    loader_state_e         state;
    loader_state_e         next_state;
    load_job_t             job_q;
    logic [LEN_W-1:0]      idx_q;
    logic [LEN_W-1:0]      idx_nxt;
    logic [DMEM_A_LEN-1:0] addr_q;
    logic [BYTE_W-1:0]     data_q;
    logic                  last_word;

    assign idx_nxt   = idx_q + 1'b1;
    assign last_word = (idx_nxt == job_q.length);

    assign pop = (state == L_POP) && !empty;

    always_comb begin
        next_state = state;
        case (state)
            L_IDLE: begin
                if (job_start)
                    next_state = L_POP;
            end
            L_POP: begin
                if (!empty)
                    next_state = L_WRITE;  // stall here while buffer is dry
            end
            L_WRITE: begin
                if (dmem_rsp.ack)
                    next_state = last_word ? L_DONE : L_POP;
            end
            L_DONE: begin
                next_state = L_IDLE;
            end
            default: next_state = L_IDLE;
        endcase
    end

    always_ff @(posedge dmem_ref_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= L_IDLE;
            idx_q <= '0;
        end else begin
            state <= next_state;
            if (state == L_IDLE && job_start)
                idx_q <= '0;
            else if (state == L_WRITE && dmem_rsp.ack)
                idx_q <= idx_nxt;
        end
    end

    // job and the current byte
    always_ff @(posedge dmem_ref_clk) begin
        if (state == L_IDLE && job_start)
            job_q <= job;
        if (pop) begin
            data_q <= head[BYTE_W-1:0];                       // low byte only
            addr_q <= job_q.start + idx_q[DMEM_A_LEN-1:0];   // wraps at top of dmem
        end
    end

    // classic write cycle, held until ack, dropped the cycle after
    assign dmem_req.cyc = (state == L_WRITE);
    assign dmem_req.stb = (state == L_WRITE);
    assign dmem_req.we  = (state == L_WRITE);
    assign dmem_req.adr = addr_q;
    assign dmem_req.dat = data_q;

    assign job_done = (state == L_DONE);

endmodule

//--- hw/sdram_loader_top.sv
`timescale 1ns/10ps

module sdram_loader_top
    import loader_pkg::*;
(
    input  logic         dmem_ref_clk,
    input  logic         rst_n,
    input  host_wb_req_t host_req,
    output host_wb_rsp_t host_rsp,
    output dmem_wb_req_t dmem_req,
    input  dmem_wb_rsp_t dmem_rsp
);

    logic              push;
    logic [WORD_W-1:0] push_data;
    logic              full;
    logic              pop;
    logic              empty;
    logic [WORD_W-1:0] head;
    logic              job_start;
    load_job_t         job;
    logic              job_done;

    // producer, takes setup and data from the host
    host_write_port u_host_port (
        .dmem_ref_clk (dmem_ref_clk),
        .rst_n        (rst_n),
        .host_req     (host_req),
        .host_rsp     (host_rsp),
        .push         (push),
        .push_data    (push_data),
        .full         (full),
        .job_start    (job_start),
        .job          (job),
        .job_done     (job_done)
    );

    word_fifo u_word_fifo (
        .dmem_ref_clk (dmem_ref_clk),
        .rst_n        (rst_n),
        .push         (push),
        .push_data    (push_data),
        .full         (full),
        .pop          (pop),
        .empty        (empty),
        .head         (head)
    );

    // consumer, writes bytes out to data memory
    dmem_loader u_dmem_loader (
        .dmem_ref_clk (dmem_ref_clk),
        .rst_n        (rst_n),
        .job_start    (job_start),
        .job          (job),
        .job_done     (job_done),
        .empty        (empty),
        .head         (head),
        .pop          (pop),
        .dmem_req     (dmem_req),
        .dmem_rsp     (dmem_rsp)
    );

endmodule

//--- sim/tb_sdram_loader.sv
`timescale 1ns/10ps

module tb_sdram_loader
    import loader_pkg::*;
();

    typedef logic [WORD_W-1:0] word_q_t[$];

    localparam int CLK_PERIOD  = 20;
    localparam int SEED        = 74677;
    localparam int MEM_SIZE    = 1 << DMEM_A_LEN;
    localparam int ACK_LIMIT   = 100;  // cycles for one host access
    localparam int POLL_LIMIT  = 500;
    // words sent over all tests including idle and extra ones
    localparam int TOTAL_WORDS = 8 + 40 + 11 + 13 + 6;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 10 + 6 * 60;  // setup and polling per test

    logic         dmem_ref_clk = 1'b0;
    logic         rst_n;
    host_wb_req_t host_req;
    host_wb_rsp_t host_rsp;
    dmem_wb_req_t dmem_req;
    dmem_wb_rsp_t dmem_rsp = '0;

    logic [BYTE_W-1:0] dmem    [MEM_SIZE];
    logic [BYTE_W-1:0] exp_mem [MEM_SIZE];
    int dmem_writes = 0;
    bit rand_delay  = 1'b0;
    int stretch_cnt = 0;  // host writes whose ack came late
    int fail_cnt    = 0;

    sdram_loader_top DUT (
        .dmem_ref_clk (dmem_ref_clk),
        .rst_n        (rst_n),
        .host_req     (host_req),
        .host_rsp     (host_rsp),
        .dmem_req     (dmem_req),
        .dmem_rsp     (dmem_rsp)
    );

    always #(CLK_PERIOD / 2) dmem_ref_clk = ~dmem_ref_clk;

    // background pattern built from every address bit
    function automatic logic [BYTE_W-1:0] fill_byte(input int a);
        logic [DMEM_A_LEN-1:0] adr;
        adr = a[DMEM_A_LEN-1:0];
        return adr[7:0] ^ {adr[13:8], adr[13:12]};
    endfunction

    function automatic word_q_t random_words(input int n);
        word_q_t words;
        for (int i = 0; i < n; i++)
            words.push_back(WORD_W'($urandom));
        return words;
    endfunction

    task automatic stop_with_failure(input string reason);
        if (reason != "")
            $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_cnt++;
            $display("ERR t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp);
            stop_with_failure("");
        end
    endtask

    // data memory model acks for one cycle after 0 to 5 wait cycles
    initial begin : dmem_model
        bit pending;
        int wait_left;
        pending   = 1'b0;
        wait_left = 0;
        for (int a = 0; a < MEM_SIZE; a++)
            dmem[a] = fill_byte(a);
        forever begin
            @(negedge dmem_ref_clk);
            if (dmem_rsp.ack) begin
                dmem_rsp.ack = 1'b0;
            end else if (rst_n === 1'b1 && dmem_req.cyc && dmem_req.stb && dmem_req.we) begin
                if (!pending) begin
                    pending   = 1'b1;
                    wait_left = rand_delay ? int'($urandom_range(5, 0)) : 0;
                end
                if (wait_left == 0) begin
                    dmem[dmem_req.adr] = dmem_req.dat;
                    dmem_writes++;
                    pending      = 1'b0;
                    dmem_rsp.ack = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // called on a falling edge and returns on one
    task automatic host_write(input host_reg_e reg_sel, input logic [WORD_W-1:0] value);
        int waited;
        waited       = 0;
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = 1'b1;
        host_req.adr = reg_sel;
        host_req.dat = value;
        do begin
            @(negedge dmem_ref_clk);
            waited++;
            if (waited > ACK_LIMIT)
                stop_with_failure("host write got no ack");
        end while (!host_rsp.ack);
        if (waited > 1)
            stretch_cnt++;
        host_req.cyc = 1'b0;
        host_req.stb = 1'b0;
        host_req.we  = 1'b0;
        @(negedge dmem_ref_clk);  // stb low for a cycle
    endtask

    task automatic host_read(input host_reg_e reg_sel, output logic [WORD_W-1:0] value);
        int waited;
        waited       = 0;
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = 1'b0;
        host_req.adr = reg_sel;
        do begin
            @(negedge dmem_ref_clk);
            waited++;
            if (waited > ACK_LIMIT)
                stop_with_failure("host read got no ack");
        end while (!host_rsp.ack);
        value        = host_rsp.dat;
        host_req.cyc = 1'b0;
        host_req.stb = 1'b0;
        @(negedge dmem_ref_clk);
    endtask

    task automatic wait_idle();
        logic [WORD_W-1:0] st;
        int polls;
        polls = 0;
        do begin
            host_read(REG_STATUS, st);
            polls++;
            if (polls > POLL_LIMIT)
                stop_with_failure("busy never fell after the load");
        end while (st[WORD_W-1]);
    endtask

    task automatic setup_job(input int start, input int len);
        host_write(REG_START, WORD_W'(start));
        host_write(REG_LENGTH, WORD_W'(len));
    endtask

    task automatic send_words(input word_q_t words);
        foreach (words[i])
            host_write(REG_DATA, words[i]);
    endtask

    task automatic compare_memory();
        for (int a = 0; a < MEM_SIZE; a++)
            check_eq($sformatf("dmem[%0d]", a), 32'(dmem[a]), 32'(exp_mem[a]));
    endtask

    // low byte of word i lands at start + i and nothing else moves
    task automatic finish_check(input int start, input word_q_t words, input int base);
        logic [WORD_W-1:0] st;
        foreach (words[i])
            exp_mem[(start + i) % MEM_SIZE] = words[i][BYTE_W-1:0];
        compare_memory();
        host_read(REG_STATUS, st);
        check_eq("status", 32'(st), words.size());
        check_eq("dmem write count", dmem_writes - base, words.size());
    endtask

    task automatic reset_state();
        logic [WORD_W-1:0] st;
        host_read(REG_STATUS, st);
        check_eq("status", 32'(st), 0);
        check_eq("dmem write count", dmem_writes, 0);
    endtask

    task automatic basic_load();
        word_q_t words;
        int base;
        base  = dmem_writes;
        words = random_words(8);
        setup_job(16'h1A40, 8);
        send_words(words);
        wait_idle();
        finish_check(16'h1A40, words, base);
    endtask

    task automatic back_pressure();
        word_q_t words;
        int base;
        base        = dmem_writes;
        words       = random_words(40);
        rand_delay  = 1'b1;
        stretch_cnt = 0;
        setup_job(16'h0A00, 40);
        send_words(words);  // faster than the loader drains
        wait_idle();
        rand_delay = 1'b0;
        finish_check(16'h0A00, words, base);
        check_eq("ack stretched", stretch_cnt > 0, 1);
    endtask

    task automatic drop_extra_words();
        word_q_t kept;
        int base;
        base = dmem_writes;
        kept = random_words(6);
        host_write(REG_START, 16'h0800);
        send_words(random_words(2));  // dropped while idle
        host_write(REG_LENGTH, 16'd6);
        send_words(kept);
        send_words(random_words(3));  // beyond length
        wait_idle();
        finish_check(16'h0800, kept, base);
    endtask

    task automatic start_while_busy();
        word_q_t words;
        word_q_t more;
        int base;
        base  = dmem_writes;
        words = random_words(10);
        more  = random_words(3);
        setup_job(16'h2C00, 10);
        for (int i = 0; i < 4; i++)
            host_write(REG_DATA, words[i]);
        host_write(REG_START, 16'h0100);
        for (int i = 4; i < 10; i++)
            host_write(REG_DATA, words[i]);
        wait_idle();
        finish_check(16'h2C00, words, base);
        // next job has no start write and reuses the kept start address
        base = dmem_writes;
        host_write(REG_LENGTH, 16'd3);
        send_words(more);
        wait_idle();
        finish_check(16'h2C00, more, base);
    endtask

    task automatic wrap_around();
        word_q_t words;
        int base;
        base  = dmem_writes;
        words = random_words(6);
        setup_job(MEM_SIZE - 3, 6);  // last three bytes at 0, 1, 2
        send_words(words);
        wait_idle();
        finish_check(MEM_SIZE - 3, words, base);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n    = 1'b0;
        host_req = '0;
        for (int a = 0; a < MEM_SIZE; a++)
            exp_mem[a] = fill_byte(a);
        repeat (2) @(posedge dmem_ref_clk);
        @(negedge dmem_ref_clk);
        rst_n = 1'b1;
        @(negedge dmem_ref_clk);
        reset_state();
        basic_load();
        back_pressure();
        drop_extra_words();
        start_while_busy();
        wrap_around();
        if (fail_cnt == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            stop_with_failure("some checks did not match");
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_failure("watchdog expired, the tests did not finish in time");
    end

endmodule

//--- files.f
hw/loader_pkg.sv
hw/host_write_port.sv
hw/word_fifo.sv
hw/dmem_loader.sv
hw/sdram_loader_top.sv
sim/tb_sdram_loader.sv

//--- run.sh
#!/bin/sh
# build and run the loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_sdram_loader \
    -Mdir obj_dir -o tb_sdram_loader
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sdram_loader 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
